// File: files.f
logic/lsu_pkg.sv
logic/amo_pkg.sv
logic/lsu_req_if.sv
logic/lsu_ctrl.sv
logic/store_align.sv
logic/load_extend.sv
logic/amo_alu.sv
logic/lsu_top.sv
test/dmem_model.sv
test/tb_lsu.sv

// File: logic/amo_alu.sv
`timescale 1ns/1ps
`default_nettype none

module amo_alu (
    lsu_req_if.data_mp             req,
    // old memory word
    input  wire lsu_pkg::xlen_t    loaded_i,
    output lsu_pkg::xlen_t         result_o
);

    logic slt;
    logic ult;

    // old word below the request word
    assign slt = $signed(loaded_i) < $signed(req.wdata);
    assign ult = loaded_i < req.wdata;

    always_comb begin
        case (req.amo_op)
            amo_pkg::AMO_SWAP: begin
                result_o = req.wdata;
            end
            amo_pkg::AMO_ADD: begin
                result_o = loaded_i + req.wdata;
            end
            amo_pkg::AMO_XOR: begin
                result_o = loaded_i ^ req.wdata;
            end
            amo_pkg::AMO_AND: begin
                result_o = loaded_i & req.wdata;
            end
            amo_pkg::AMO_OR: begin
                result_o = loaded_i | req.wdata;
            end
            // signed pair
            amo_pkg::AMO_MIN: begin
                result_o = slt ? loaded_i : req.wdata;
            end
            amo_pkg::AMO_MAX: begin
                result_o = slt ? req.wdata : loaded_i;
            end
            // unsigned pair
            amo_pkg::AMO_MINU: begin
                result_o = ult ? loaded_i : req.wdata;
            end
            amo_pkg::AMO_MAXU: begin
                result_o = ult ? req.wdata : loaded_i;
            end
            default: begin
                // unknown opcode leaves memory as it was
                result_o = loaded_i;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/amo_pkg.sv
`default_nettype none

package amo_pkg;

    // amo opcode width
    localparam int AMO_OP_W = 4;

    // kind of read-modify-write
    typedef enum logic [AMO_OP_W-1:0] {
        AMO_SWAP = 4'd0,
        AMO_ADD  = 4'd1,
        AMO_XOR  = 4'd2,
        AMO_AND  = 4'd3,
        AMO_OR   = 4'd4,
        // signed compare
        AMO_MIN  = 4'd5,
        AMO_MAX  = 4'd6,
        // unsigned compare
        AMO_MINU = 4'd7,
        AMO_MAXU = 4'd8
    } amo_op_e;

endpackage

`default_nettype wire

// File: logic/load_extend.sv
`timescale 1ns/1ps
`default_nettype none

module load_extend (
    lsu_req_if.data_mp             req,
    // word as returned by memory
    input  wire lsu_pkg::xlen_t    rdata_i,
    output lsu_pkg::xlen_t         data_o
);

    logic [4:0]     shamt;
    lsu_pkg::xlen_t shifted;

    // addressed byte moved down to lane 0
    assign shamt   = {req.addr[1:0], 3'b000};
    assign shifted = rdata_i >> shamt;

    always_comb begin
        case (req.op)
            lsu_pkg::MEM_LB: begin
                // sign from bit 7
                data_o = {{24{shifted[7]}}, shifted[7:0]};
            end
            lsu_pkg::MEM_LBU: begin
                data_o = {24'b0, shifted[7:0]};
            end
            lsu_pkg::MEM_LH: begin
                // sign from bit 15
                data_o = {{16{shifted[15]}}, shifted[15:0]};
            end
            lsu_pkg::MEM_LHU: begin
                data_o = {16'b0, shifted[15:0]};
            end
            default: begin
                // full word for lw, lr and amo
                data_o = rdata_i;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/lsu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl (
    input  wire                    clk,
    input  wire                    rst,
    // request side
    input  wire                    req_valid_i,
    input  wire lsu_pkg::mem_op_e  req_op_i,
    input  wire amo_pkg::amo_op_e  req_amo_op_i,
    input  wire lsu_pkg::xlen_t    req_addr_i,
    input  wire lsu_pkg::xlen_t    req_wdata_i,
    output logic                   req_ready_o,
    // response side
    output logic                   rsp_valid_o,
    input  wire                    rsp_ready_i,
    output lsu_pkg::xlen_t         rsp_data_o,
    output logic                   rsp_misalign_o,
    // memory side
    output logic                   mem_valid_o,
    input  wire                    mem_ready_i,
    output logic                   mem_write_o,
    output lsu_pkg::xlen_t         mem_addr_o,
    input  wire lsu_pkg::xlen_t    mem_rdata_i,
    // extended load value from load_extend
    input  wire lsu_pkg::xlen_t    load_data_i,
    lsu_req_if.ctrl_mp             req,
    // old word of an amo, feeds amo_alu
    output lsu_pkg::xlen_t         loaded_o
);

    typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_WRITE, ST_RSP} state_e;

    state_e           state;
    lsu_pkg::mem_op_e op_q;
    amo_pkg::amo_op_e amo_op_q;
    lsu_pkg::xlen_t   addr_q;
    lsu_pkg::xlen_t   wdata_q;
    lsu_pkg::xlen_t   loaded_q;
    lsu_pkg::xlen_t   rsp_data_q;
    logic             rsp_misalign_q;
    logic             resv_valid;
    lsu_pkg::xlen_t   resv_addr;
    logic             accept;
    logic             misalign_in;
    logic             sc_hit;

    // halfwords need bit 0 clear, word-sized ops need both low bits clear
    function automatic logic is_misaligned(input lsu_pkg::mem_op_e op, input logic [1:0] off);
        logic bad;
        case (op)
            lsu_pkg::MEM_LH, lsu_pkg::MEM_LHU, lsu_pkg::MEM_SH: bad = off[0];
            lsu_pkg::MEM_LB, lsu_pkg::MEM_LBU, lsu_pkg::MEM_SB: bad = 1'b0;
            default: bad = |off;
        endcase
        return bad;
    endfunction

    assign accept      = req_valid_i & req_ready_o;
    assign misalign_in = is_misaligned(req_op_i, req_addr_i[1:0]);
    // sc succeeds only against a live reservation on the same word
    assign sc_hit      = resv_valid && (resv_addr == req_addr_i);

    // sequencing and reservation flag
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= ST_IDLE;
            resv_valid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        if (misalign_in) begin
                            // no transfer, reservation untouched
                            state <= ST_RSP;
                        end else begin
                            case (req_op_i)
                                lsu_pkg::MEM_SB, lsu_pkg::MEM_SH, lsu_pkg::MEM_SW: begin
                                    state      <= ST_WRITE;
                                    resv_valid <= 1'b0;
                                end
                                lsu_pkg::MEM_SC_W: begin
                                    state      <= sc_hit ? ST_WRITE : ST_RSP;
                                    resv_valid <= 1'b0;
                                end
                                lsu_pkg::MEM_LR_W: begin
                                    state      <= ST_READ;
                                    resv_valid <= 1'b1;
                                end
                                lsu_pkg::MEM_AMO: begin
                                    state      <= ST_READ;
                                    resv_valid <= 1'b0;
                                end
                                // plain loads keep the reservation
                                default: state <= ST_READ;
                            endcase
                        end
                    end
                end
                ST_READ: begin
                    // amo goes on to its write half
                    if (mem_ready_i) begin
                        state <= (op_q == lsu_pkg::MEM_AMO) ? ST_WRITE : ST_RSP;
                    end
                end
                ST_WRITE: begin
                    if (mem_ready_i) begin
                        state <= ST_RSP;
                    end
                end
                ST_RSP: begin
                    // held here under back-pressure
                    if (rsp_ready_i) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // request, reservation address and response payload
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q           <= req_op_i;
            amo_op_q       <= req_amo_op_i;
            addr_q         <= req_addr_i;
            wdata_q        <= req_wdata_i;
            rsp_misalign_q <= misalign_in;
            if (misalign_in) begin
                rsp_data_q <= '0;
            end else if (req_op_i == lsu_pkg::MEM_SC_W && !sc_hit) begin
                // failed sc reports 1
                rsp_data_q <= lsu_pkg::xlen_t'(1);
            end
            if (req_op_i == lsu_pkg::MEM_LR_W && !misalign_in) begin
                resv_addr <= req_addr_i;
            end
        end
        if (state == ST_READ && mem_ready_i) begin
            loaded_q   <= mem_rdata_i;
            // extended value for loads, raw word for lr and amo
            rsp_data_q <= load_data_i;
        end
        if (state == ST_WRITE && mem_ready_i) begin
            // amo returns the old word, stores and sc return zero
            rsp_data_q <= (op_q == lsu_pkg::MEM_AMO) ? loaded_q : '0;
        end
    end

    // decoded outputs
    assign req_ready_o    = (state == ST_IDLE);
    assign rsp_valid_o    = (state == ST_RSP);
    assign mem_valid_o    = (state == ST_READ) || (state == ST_WRITE);
    assign mem_write_o    = (state == ST_WRITE);
    assign mem_addr_o     = {addr_q[lsu_pkg::XLEN-1:2], 2'b00};
    assign rsp_data_o     = rsp_data_q;
    assign rsp_misalign_o = rsp_misalign_q;
    assign loaded_o       = loaded_q;

    // held request to the datapath
    assign req.op     = op_q;
    assign req.amo_op = amo_op_q;
    assign req.addr   = addr_q;
    assign req.wdata  = wdata_q;

endmodule

`default_nettype wire

// File: logic/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // data and address width
    localparam int XLEN = 32;

    // byte lanes per word
    localparam int STRB_W = XLEN / 8;

    // one address or data word
    typedef logic [XLEN-1:0] xlen_t;

    // one strobe bit per byte lane
    typedef logic [STRB_W-1:0] strb_t;

    // memory op carried with each request
    typedef enum logic [3:0] {
        // plain loads
        MEM_LB   = 4'd0,
        MEM_LBU  = 4'd1,
        MEM_LH   = 4'd2,
        MEM_LHU  = 4'd3,
        MEM_LW   = 4'd4,
        // plain stores
        MEM_SB   = 4'd5,
        MEM_SH   = 4'd6,
        MEM_SW   = 4'd7,
        // reservation pair
        MEM_LR_W = 4'd8,
        MEM_SC_W = 4'd9,
        // read-modify-write, kind given by the amo opcode
        MEM_AMO  = 4'd10
    } mem_op_e;

endpackage

`default_nettype wire

// File: logic/lsu_req_if.sv
`timescale 1ns/1ps
`default_nettype none

// accepted request, held by control for the whole access
interface lsu_req_if;

    lsu_pkg::mem_op_e op;
    amo_pkg::amo_op_e amo_op;
    lsu_pkg::xlen_t   addr;
    lsu_pkg::xlen_t   wdata;

    // control owns the registers
    modport ctrl_mp (
        output op, amo_op, addr, wdata
    );

    // datapath blocks only look
    modport data_mp (
        input op, amo_op, addr, wdata
    );

endinterface

`default_nettype wire

// File: logic/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
    input  wire                    clk,
    input  wire                    rst,
    // request
    input  wire                    req_valid_i,
    input  wire lsu_pkg::mem_op_e  req_op_i,
    input  wire amo_pkg::amo_op_e  req_amo_op_i,
    input  wire lsu_pkg::xlen_t    req_addr_i,
    input  wire lsu_pkg::xlen_t    req_wdata_i,
    output wire                    req_ready_o,
    // response
    output wire                    rsp_valid_o,
    input  wire                    rsp_ready_i,
    output wire lsu_pkg::xlen_t    rsp_data_o,
    output wire                    rsp_misalign_o,
    // data memory
    output wire                    mem_valid_o,
    input  wire                    mem_ready_i,
    output wire                    mem_write_o,
    output wire lsu_pkg::xlen_t    mem_addr_o,
    output wire lsu_pkg::strb_t    mem_wstrb_o,
    output wire lsu_pkg::xlen_t    mem_wdata_o,
    input  wire lsu_pkg::xlen_t    mem_rdata_i
);

    lsu_pkg::xlen_t load_data;
    lsu_pkg::xlen_t loaded;
    lsu_pkg::xlen_t amo_result;
    lsu_pkg::strb_t wstrb;

    // held request shared by control and datapath
    lsu_req_if req_bus ();

    lsu_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .req_valid_i    (req_valid_i),
        .req_op_i       (req_op_i),
        .req_amo_op_i   (req_amo_op_i),
        .req_addr_i     (req_addr_i),
        .req_wdata_i    (req_wdata_i),
        .req_ready_o    (req_ready_o),
        .rsp_valid_o    (rsp_valid_o),
        .rsp_ready_i    (rsp_ready_i),
        .rsp_data_o     (rsp_data_o),
        .rsp_misalign_o (rsp_misalign_o),
        .mem_valid_o    (mem_valid_o),
        .mem_ready_i    (mem_ready_i),
        .mem_write_o    (mem_write_o),
        .mem_addr_o     (mem_addr_o),
        .mem_rdata_i    (mem_rdata_i),
        .load_data_i    (load_data),
        .req            (req_bus.ctrl_mp),
        .loaded_o       (loaded)
    );

    store_align u_store_align (
        .req          (req_bus.data_mp),
        .amo_result_i (amo_result),
        .wstrb_o      (wstrb),
        .wdata_o      (mem_wdata_o)
    );

    load_extend u_load_extend (
        .req     (req_bus.data_mp),
        .rdata_i (mem_rdata_i),
        .data_o  (load_data)
    );

    amo_alu u_amo_alu (
        .req      (req_bus.data_mp),
        .loaded_i (loaded),
        .result_o (amo_result)
    );

    // strobes only mean something on a write
    assign mem_wstrb_o = mem_write_o ? wstrb : '0;

endmodule

`default_nettype wire

// File: logic/store_align.sv
`timescale 1ns/1ps
`default_nettype none

module store_align (
    lsu_req_if.data_mp             req,
    // new word from amo_alu
    input  wire lsu_pkg::xlen_t    amo_result_i,
    output lsu_pkg::strb_t         wstrb_o,
    output lsu_pkg::xlen_t         wdata_o
);

    logic [1:0] offset;
    logic [4:0] shamt;

    // byte offset inside the word
    assign offset = req.addr[1:0];
    // eight bits per byte of offset
    assign shamt  = {offset, 3'b000};

    always_comb begin
        case (req.op)
            lsu_pkg::MEM_SB: begin
                wstrb_o = lsu_pkg::strb_t'(4'b0001) << offset;
                wdata_o = req.wdata << shamt;
            end
            lsu_pkg::MEM_SH: begin
                wstrb_o = lsu_pkg::strb_t'(4'b0011) << offset;
                wdata_o = req.wdata << shamt;
            end
            lsu_pkg::MEM_SW: begin
                // aligned, offset is zero
                wstrb_o = '1;
                wdata_o = req.wdata;
            end
            lsu_pkg::MEM_SC_W: begin
                wstrb_o = '1;
                wdata_o = req.wdata;
            end
            lsu_pkg::MEM_AMO: begin
                // write half writes the alu result
                wstrb_o = '1;
                wdata_o = amo_result_i;
            end
            default: begin
                // loads and lr never write
                wstrb_o = '0;
                wdata_o = req.wdata;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: test/dmem_init.hex
// one 32-bit word per line, word index 0 to 15, byte address is index times 4
80817F01
12345678
FEDCBA98
0BADF00D
11111111
22222222
33333333
44444444
00000005
F0F0F0F0
FFFF0000
000000F0
00000005
FFFFFFF0
80000000
00000010

// File: test/dmem_model.sv
`timescale 1ns/1ps
`default_nettype none

module dmem_model (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    mem_valid_i,
    output logic                   mem_ready_o,
    input  wire                    mem_write_i,
    input  wire lsu_pkg::xlen_t    mem_addr_i,
    input  wire lsu_pkg::strb_t    mem_wstrb_i,
    input  wire lsu_pkg::xlen_t    mem_wdata_i,
    output lsu_pkg::xlen_t         mem_rdata_o
);

    // 16 words, byte addresses 0x00 to 0x3c
    lsu_pkg::xlen_t mem [0:15];
    logic [3:0]     index;
    // cycles still to wait before ready
    int unsigned    wait_cnt;

    initial begin
        $readmemh("test/dmem_init.hex", mem);
    end

    assign index       = mem_addr_i[5:2];
    assign mem_ready_o = mem_valid_i && (wait_cnt == 0);
    // read data valid in the completing cycle
    assign mem_rdata_o = mem[index];

    // random 0 to 3 cycle delay per transfer
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            wait_cnt <= 0;
        end else if (mem_valid_i) begin
            if (wait_cnt != 0) begin
                wait_cnt <= wait_cnt - 1;
            end else begin
                // done, draw the delay for the next transfer
                wait_cnt <= $urandom % 4;
            end
        end
    end

    // byte lanes written on the completing edge
    always @(posedge clk) begin
        if (mem_valid_i && mem_ready_o && mem_write_i) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_wstrb_i[b]) begin
                    mem[index][8*b +: 8] <= mem_wdata_i[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: test/tb_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lsu;

    // one table row, follow-up lw reads the same word
    typedef struct packed {
        lsu_pkg::mem_op_e op;
        amo_pkg::amo_op_e amo;
        lsu_pkg::xlen_t   addr;
        lsu_pkg::xlen_t   wdata;
        lsu_pkg::xlen_t   exp_data;
        logic             exp_mis;
        logic             chk;
        lsu_pkg::xlen_t   chk_word;
    } row_t;

    logic             clk = 1'b0;
    logic             rst;
    logic             req_valid_i;
    lsu_pkg::mem_op_e req_op_i;
    amo_pkg::amo_op_e req_amo_op_i;
    lsu_pkg::xlen_t   req_addr_i;
    lsu_pkg::xlen_t   req_wdata_i;
    logic             req_ready_o;
    logic             rsp_valid_o;
    logic             rsp_ready_i;
    lsu_pkg::xlen_t   rsp_data_o;
    logic             rsp_misalign_o;
    logic             mem_valid_o;
    logic             mem_ready_i;
    logic             mem_write_o;
    lsu_pkg::xlen_t   mem_addr_o;
    lsu_pkg::strb_t   mem_wstrb_o;
    lsu_pkg::xlen_t   mem_wdata_o;
    lsu_pkg::xlen_t   mem_rdata_i;

    row_t tests[$];
    logic table_ready = 1'b0;
    int   test_errors = 0;
    int   pass_count = 0;
    int   fail_count = 0;

    // memory transfers completed during the current access
    int             read_xfers = 0;
    int             write_xfers = 0;
    lsu_pkg::xlen_t exp_mem_addr = '0;

    // 100 ns period
    always #50 clk = ~clk;

    lsu_top DUT (
        .clk            (clk),
        .rst            (rst),
        .req_valid_i    (req_valid_i),
        .req_op_i       (req_op_i),
        .req_amo_op_i   (req_amo_op_i),
        .req_addr_i     (req_addr_i),
        .req_wdata_i    (req_wdata_i),
        .req_ready_o    (req_ready_o),
        .rsp_valid_o    (rsp_valid_o),
        .rsp_ready_i    (rsp_ready_i),
        .rsp_data_o     (rsp_data_o),
        .rsp_misalign_o (rsp_misalign_o),
        .mem_valid_o    (mem_valid_o),
        .mem_ready_i    (mem_ready_i),
        .mem_write_o    (mem_write_o),
        .mem_addr_o     (mem_addr_o),
        .mem_wstrb_o    (mem_wstrb_o),
        .mem_wdata_o    (mem_wdata_o),
        .mem_rdata_i    (mem_rdata_i)
    );

    dmem_model u_dmem (
        .clk         (clk),
        .rst         (rst),
        .mem_valid_i (mem_valid_o),
        .mem_ready_o (mem_ready_i),
        .mem_write_i (mem_write_o),
        .mem_addr_i  (mem_addr_o),
        .mem_wstrb_i (mem_wstrb_o),
        .mem_wdata_i (mem_wdata_o),
        .mem_rdata_o (mem_rdata_i)
    );

    task automatic check_word(input string name, input lsu_pkg::xlen_t exp,
                              input lsu_pkg::xlen_t got);
        if (got !== exp) begin
            $display("Mismatch %s expected 0x%08h got 0x%08h", name, exp, got);
            test_errors = test_errors + 1;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("Mismatch %s expected 0x%0h got 0x%0h", name, exp, got);
            test_errors = test_errors + 1;
        end
    endtask

    // sampled mid-cycle, the transfer completes on the next rising edge
    always @(negedge clk) begin
        if (mem_valid_o && mem_ready_i) begin
            check_word("mem_addr_o", exp_mem_addr, mem_addr_o);
            if (mem_write_o) begin
                write_xfers = write_xfers + 1;
            end else begin
                read_xfers = read_xfers + 1;
            end
        end
    end

    task automatic add_row(input lsu_pkg::mem_op_e op, input amo_pkg::amo_op_e amo,
                           input lsu_pkg::xlen_t addr, input lsu_pkg::xlen_t wdata,
                           input lsu_pkg::xlen_t exp_data, input logic exp_mis,
                           input logic chk, input lsu_pkg::xlen_t chk_word);
        row_t row;
        row.op       = op;
        row.amo      = amo;
        row.addr     = addr;
        row.wdata    = wdata;
        row.exp_data = exp_data;
        row.exp_mis  = exp_mis;
        row.chk      = chk;
        row.chk_word = chk_word;
        tests.push_back(row);
    endtask

    // loads and lr, no follow-up
    task automatic add_load(input lsu_pkg::mem_op_e op, input lsu_pkg::xlen_t addr,
                            input lsu_pkg::xlen_t exp_data);
        add_row(op, amo_pkg::AMO_SWAP, addr, '0, exp_data, 1'b0, 1'b0, '0);
    endtask

    // stores and sc, word read back afterwards
    task automatic add_write(input lsu_pkg::mem_op_e op, input lsu_pkg::xlen_t addr,
                             input lsu_pkg::xlen_t wdata, input lsu_pkg::xlen_t exp_data,
                             input lsu_pkg::xlen_t chk_word);
        add_row(op, amo_pkg::AMO_SWAP, addr, wdata, exp_data, 1'b0, 1'b1, chk_word);
    endtask

    task automatic add_amo(input amo_pkg::amo_op_e amo, input lsu_pkg::xlen_t addr,
                           input lsu_pkg::xlen_t wdata, input lsu_pkg::xlen_t old_word,
                           input lsu_pkg::xlen_t new_word);
        add_row(lsu_pkg::MEM_AMO, amo, addr, wdata, old_word, 1'b0, 1'b1, new_word);
    endtask

    // zero data, flag set, memory word unchanged
    task automatic add_misaligned(input lsu_pkg::mem_op_e op, input amo_pkg::amo_op_e amo,
                                  input lsu_pkg::xlen_t addr, input lsu_pkg::xlen_t chk_word);
        add_row(op, amo, addr, 'hFFFFFFFF, '0, 1'b1, 1'b1, chk_word);
    endtask

    // read transfers one row should cause
    function automatic int expected_reads(input row_t row);
        int n;
        n = 0;
        if (!row.exp_mis) begin
            case (row.op)
                lsu_pkg::MEM_SB, lsu_pkg::MEM_SH, lsu_pkg::MEM_SW, lsu_pkg::MEM_SC_W: n = 0;
                default: n = 1;
            endcase
        end
        return n;
    endfunction

    // write transfers one row should cause
    function automatic int expected_writes(input row_t row);
        int n;
        n = 0;
        if (!row.exp_mis) begin
            case (row.op)
                lsu_pkg::MEM_SB, lsu_pkg::MEM_SH, lsu_pkg::MEM_SW, lsu_pkg::MEM_AMO: n = 1;
                // a failed sc writes nothing
                lsu_pkg::MEM_SC_W: n = (row.exp_data == '0) ? 1 : 0;
                default: n = 0;
            endcase
        end
        return n;
    endfunction

    // expected values from dmem_init.hex, rows depend on earlier rows
    task automatic build_table();
        // word 0 is 80817f01
        add_load(lsu_pkg::MEM_LB, 'h00, 'h00000001);
        add_load(lsu_pkg::MEM_LB, 'h01, 'h0000007F);
        add_load(lsu_pkg::MEM_LB, 'h02, 'hFFFFFF81);
        add_load(lsu_pkg::MEM_LB, 'h03, 'hFFFFFF80);
        add_load(lsu_pkg::MEM_LBU, 'h00, 'h00000001);
        add_load(lsu_pkg::MEM_LBU, 'h01, 'h0000007F);
        add_load(lsu_pkg::MEM_LBU, 'h02, 'h00000081);
        add_load(lsu_pkg::MEM_LBU, 'h03, 'h00000080);
        add_load(lsu_pkg::MEM_LH, 'h00, 'h00007F01);
        // word 2 is fedcba98
        add_load(lsu_pkg::MEM_LH, 'h08, 'hFFFFBA98);
        add_load(lsu_pkg::MEM_LH, 'h0A, 'hFFFFFEDC);
        add_load(lsu_pkg::MEM_LHU, 'h08, 'h0000BA98);
        add_load(lsu_pkg::MEM_LHU, 'h02, 'h00008081);
        add_load(lsu_pkg::MEM_LW, 'h04, 'h12345678);
        // byte and halfword lanes, upper wdata bits must be ignored
        add_write(lsu_pkg::MEM_SB, 'h10, 'hCAFE00AA, 'h0, 'h111111AA);
        add_write(lsu_pkg::MEM_SB, 'h11, 'h000000BB, 'h0, 'h1111BBAA);
        add_write(lsu_pkg::MEM_SB, 'h12, 'h000000CC, 'h0, 'h11CCBBAA);
        add_write(lsu_pkg::MEM_SB, 'h13, 'h000000DD, 'h0, 'hDDCCBBAA);
        add_write(lsu_pkg::MEM_SH, 'h14, 'h0000BEEF, 'h0, 'h2222BEEF);
        add_write(lsu_pkg::MEM_SH, 'h16, 'h1234CAFE, 'h0, 'hCAFEBEEF);
        add_write(lsu_pkg::MEM_SW, 'h18, 'h01234567, 'h0, 'h01234567);
        // amo returns the old word
        add_amo(amo_pkg::AMO_SWAP, 'h1C, 'hA5A5A5A5, 'h44444444, 'hA5A5A5A5);
        add_amo(amo_pkg::AMO_ADD, 'h20, 'hFFFFFFFE, 'h00000005, 'h00000003);
        add_amo(amo_pkg::AMO_XOR, 'h24, 'hFF00FF00, 'hF0F0F0F0, 'h0FF00FF0);
        add_amo(amo_pkg::AMO_AND, 'h28, 'h0FF00FF0, 'hFFFF0000, 'h0FF00000);
        add_amo(amo_pkg::AMO_OR, 'h2C, 'h0000000F, 'h000000F0, 'h000000FF);
        // signed and unsigned picks differ for each of these
        add_amo(amo_pkg::AMO_MIN, 'h30, 'hFFFFFFF0, 'h00000005, 'hFFFFFFF0);
        add_amo(amo_pkg::AMO_MAX, 'h34, 'h00000002, 'hFFFFFFF0, 'h00000002);
        add_amo(amo_pkg::AMO_MINU, 'h38, 'h00000007, 'h80000000, 'h00000007);
        add_amo(amo_pkg::AMO_MAXU, 'h3C, 'hFFFFFFFF, 'h00000010, 'hFFFFFFFF);
        // lr then sc succeeds, second sc has no reservation
        add_load(lsu_pkg::MEM_LR_W, 'h0C, 'h0BADF00D);
        add_write(lsu_pkg::MEM_SC_W, 'h0C, 'h600DC0DE, 'h0, 'h600DC0DE);
        add_write(lsu_pkg::MEM_SC_W, 'h0C, 'h12121212, 'h1, 'h600DC0DE);
        // plain store kills the reservation
        add_load(lsu_pkg::MEM_LR_W, 'h04, 'h12345678);
        add_write(lsu_pkg::MEM_SW, 'h04, 'h55AA55AA, 'h0, 'h55AA55AA);
        add_write(lsu_pkg::MEM_SC_W, 'h04, 'h77777777, 'h1, 'h55AA55AA);
        // plain load keeps it
        add_load(lsu_pkg::MEM_LR_W, 'h08, 'hFEDCBA98);
        add_load(lsu_pkg::MEM_LW, 'h08, 'hFEDCBA98);
        add_write(lsu_pkg::MEM_SC_W, 'h08, 'h13579BDF, 'h0, 'h13579BDF);
        // misaligned accesses touch nothing
        add_misaligned(lsu_pkg::MEM_LH, amo_pkg::AMO_SWAP, 'h01, 'h80817F01);
        add_misaligned(lsu_pkg::MEM_LW, amo_pkg::AMO_SWAP, 'h06, 'h55AA55AA);
        add_misaligned(lsu_pkg::MEM_AMO, amo_pkg::AMO_ADD, 'h22, 'h00000003);
        add_misaligned(lsu_pkg::MEM_SW, amo_pkg::AMO_SWAP, 'h1A, 'h01234567);
        add_misaligned(lsu_pkg::MEM_SH, amo_pkg::AMO_SWAP, 'h13, 'hDDCCBBAA);
        // and leave the reservation alone
        add_load(lsu_pkg::MEM_LR_W, 'h0C, 'h600DC0DE);
        add_misaligned(lsu_pkg::MEM_SW, amo_pkg::AMO_SWAP, 'h0E, 'h600DC0DE);
        add_write(lsu_pkg::MEM_SC_W, 'h0C, 'h0A0A0A0A, 'h0, 'h0A0A0A0A);
    endtask

    // one request and its response, entered and left 10 ns after an edge
    task automatic do_access(input lsu_pkg::mem_op_e op, input amo_pkg::amo_op_e amo,
                             input lsu_pkg::xlen_t addr, input lsu_pkg::xlen_t wdata,
                             output lsu_pkg::xlen_t data, output logic mis);
        int unsigned stall;
        // memory only ever sees the word address
        exp_mem_addr = {addr[lsu_pkg::XLEN-1:2], 2'b00};
        read_xfers   = 0;
        write_xfers  = 0;
        req_valid_i  = 1'b1;
        req_op_i     = op;
        req_amo_op_i = amo;
        req_addr_i   = addr;
        req_wdata_i  = wdata;
        while (!req_ready_o) begin
            @(posedge clk);
            #10;
        end
        // accepted on this edge
        @(posedge clk);
        #10;
        req_valid_i = 1'b0;
        while (!rsp_valid_o) begin
            check_flag("req_ready_o", 1'b0, req_ready_o);
            @(posedge clk);
            #10;
        end
        data = rsp_data_o;
        mis  = rsp_misalign_o;
        // hold off the response, it must not move
        stall = $urandom % 3;
        repeat (stall) begin
            @(posedge clk);
            #10;
            check_flag("rsp_valid_o", 1'b1, rsp_valid_o);
            check_word("rsp_data_o", data, rsp_data_o);
            check_flag("rsp_misalign_o", mis, rsp_misalign_o);
            check_flag("req_ready_o", 1'b0, req_ready_o);
        end
        rsp_ready_i = 1'b1;
        @(posedge clk);
        #10;
        rsp_ready_i = 1'b0;
        // exactly one response per request
        check_flag("rsp_valid_o", 1'b0, rsp_valid_o);
    endtask

    initial begin
        row_t           row;
        lsu_pkg::xlen_t data;
        logic           mis;
        int unsigned    seed_draw;
        seed_draw    = $urandom(81672);
        rst          = 1'b1;
        req_valid_i  = 1'b0;
        req_op_i     = lsu_pkg::MEM_LW;
        req_amo_op_i = amo_pkg::AMO_SWAP;
        req_addr_i   = '0;
        req_wdata_i  = '0;
        rsp_ready_i  = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (10) @(posedge clk);
        #10;
        rst = 1'b0;
        for (int i = 0; i < tests.size(); i++) begin
            row         = tests[i];
            test_errors = 0;
            do_access(row.op, row.amo, row.addr, row.wdata, data, mis);
            check_word("rsp_data_o", row.exp_data, data);
            check_flag("rsp_misalign_o", row.exp_mis, mis);
            // transfers seen by the memory monitor
            check_word("mem_valid_o read count", expected_reads(row), read_xfers);
            check_word("mem_valid_o write count", expected_writes(row), write_xfers);
            if (row.chk) begin
                // read the whole word back
                do_access(lsu_pkg::MEM_LW, amo_pkg::AMO_SWAP, {row.addr[31:2], 2'b00},
                          '0, data, mis);
                check_word("rsp_data_o of follow-up lw", row.chk_word, data);
            end
            if (test_errors == 0) begin
                pass_count = pass_count + 1;
                $display("test %0d op %0d addr 0x%08h ok", i, row.op, row.addr);
            end else begin
                fail_count = fail_count + 1;
                $display("test %0d op %0d addr 0x%08h failed", i, row.op, row.addr);
            end
        end
        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // 20 clock periods per row plus reset
    initial begin
        int cycles;
        wait (table_ready);
        cycles = tests.size() * 20 + 10;
        #(cycles * 100);
        $display("timeout: the tests did not finish within %0d clock cycles", cycles);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire
